// ==== source/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int XLEN_INSTR = 32;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int FUNCT6_W   = 6;

    typedef logic [XLEN_INSTR-1:0] instr_t;

    // major opcodes of the RV64I base set
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_LUI       = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OPC_JAL       = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OPC_JALR      = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OPC_LOAD      = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OPC_STORE     = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OPC_OP        = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [OPCODE_W-1:0] OPC_OP_32     = 7'b0111011;

    // integer ALU funct3, shared by OP, OP-IMM and their 32-bit forms
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    localparam logic [FUNCT3_W-1:0] F3_JALR = 3'b000;

    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    localparam logic [FUNCT3_W-1:0] F3_LB  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_LH  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_LW  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_LD  = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_LBU = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_LHU = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_LWU = 3'b110;

    localparam logic [FUNCT3_W-1:0] F3_SB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SH = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SW = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SD = 3'b011;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

    // bits 31:26 pick logical or arithmetic shift when shamt is six bits wide
    localparam logic [FUNCT6_W-1:0] F6_BASE = 6'b000000;
    localparam logic [FUNCT6_W-1:0] F6_ALT  = 6'b010000;

    typedef enum logic [3:0] {
        CLASS_NONE,
        CLASS_OP_IMM,
        CLASS_LUI,
        CLASS_AUIPC,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_BRANCH,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_OP,
        CLASS_OP_IMM_32,
        CLASS_OP_32
    } op_class_t;

    typedef enum logic [5:0] {
        UNKNOWN = 6'd0,
        ADDI, XORI, ORI, ANDI, SLTI, SLTIU, SLLI, SRLI, SRAI,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        ADD, SUB, AND, OR, XOR, SLL, SLT, SLTU, SRL, SRA,
        ADDIW, SLLIW, SRLIW, SRAIW,
        ADDW, SUBW, SLLW, SRLW, SRAW
    } op_t;

    typedef enum logic [3:0] {
        ALU_PASS = 4'd0,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SSMALL,
        ALU_USMALL,
        ALU_LEFT,
        ALU_URIGHT,
        ALU_SRIGHT,
        ALU_URIGHT_32,
        ALU_SRIGHT_32,
        ALU_DIRECT
    } alu_func_t;

    typedef struct packed {
        op_class_t             op_class;
        logic [FUNCT3_W-1:0]   funct3;
        logic [FUNCT7_W-1:0]   funct7;
        logic [FUNCT6_W-1:0]   funct6;
    } decode_fields_t;

    typedef struct packed {
        op_t       op;
        alu_func_t alufunc;
        logic      regwrite;
        logic      mem_access;
    } control_t;

endpackage

`default_nettype wire

// ==== source/opcode_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

module opcode_classify (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       instr_valid,
    input  decode_pkg::instr_t         instr,
    output logic                       instr_ready,
    output logic                       fields_valid,
    output decode_pkg::decode_fields_t fields,
    input  logic                       fields_ready
);
    import decode_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    op_class_t           op_class;
    decode_fields_t      fields_d;
    decode_fields_t      fields_q;
    logic                valid_q;
    logic                accept;

    assign opcode = instr[OPCODE_W-1:0];

    always_comb begin
        case (opcode)
            OPC_OP_IMM:    op_class = CLASS_OP_IMM;
            OPC_LUI:       op_class = CLASS_LUI;
            OPC_AUIPC:     op_class = CLASS_AUIPC;
            OPC_JAL:       op_class = CLASS_JAL;
            OPC_JALR:      op_class = CLASS_JALR;
            OPC_BRANCH:    op_class = CLASS_BRANCH;
            OPC_LOAD:      op_class = CLASS_LOAD;
            OPC_STORE:     op_class = CLASS_STORE;
            OPC_OP:        op_class = CLASS_OP;
            OPC_OP_IMM_32: op_class = CLASS_OP_IMM_32;
            OPC_OP_32:     op_class = CLASS_OP_32;
            default:       op_class = CLASS_NONE;
        endcase
    end

    // register indices and immediates are not needed past this point
    always_comb begin
        fields_d.op_class = op_class;
        fields_d.funct3   = instr[14:12];
        fields_d.funct7   = instr[31:25];
        fields_d.funct6   = instr[31:26];
    end

    // the slot frees up whenever the held item leaves this cycle
    assign instr_ready = !valid_q || fields_ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (instr_ready) begin
            valid_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fields_q <= fields_d;
        end
    end

    assign fields_valid = valid_q;
    assign fields       = fields_q;

endmodule

`default_nettype wire

// ==== source/subop_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module subop_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       fields_valid,
    input  decode_pkg::decode_fields_t fields,
    output logic                       fields_ready,
    output logic                       ctl_valid,
    output decode_pkg::control_t       ctl,
    input  logic                       ctl_ready
);
    import decode_pkg::*;

    op_t      op_sel;
    control_t ctl_d;
    control_t ctl_q;
    logic     valid_q;
    logic     accept;

    // first pick the exact operation from class and function fields
    always_comb begin
        op_sel = UNKNOWN;
        case (fields.op_class)
            CLASS_OP_IMM: begin
                case (fields.funct3)
                    F3_ADD_SUB: op_sel = ADDI;
                    F3_XOR:     op_sel = XORI;
                    F3_OR:      op_sel = ORI;
                    F3_AND:     op_sel = ANDI;
                    F3_SLT:     op_sel = SLTI;
                    F3_SLTU:    op_sel = SLTIU;
                    F3_SLL:     op_sel = SLLI;
                    F3_SRL_SRA: begin
                        if (fields.funct6 == F6_BASE) begin
                            op_sel = SRLI;
                        end else if (fields.funct6 == F6_ALT) begin
                            op_sel = SRAI;
                        end
                    end
                    default:    op_sel = UNKNOWN;
                endcase
            end
            CLASS_LUI:   op_sel = LUI;
            CLASS_AUIPC: op_sel = AUIPC;
            CLASS_JAL:   op_sel = JAL;
            CLASS_JALR: begin
                if (fields.funct3 == F3_JALR) begin
                    op_sel = JALR;
                end
            end
            CLASS_BRANCH: begin
                case (fields.funct3)
                    F3_BEQ:  op_sel = BEQ;
                    F3_BNE:  op_sel = BNE;
                    F3_BLT:  op_sel = BLT;
                    F3_BGE:  op_sel = BGE;
                    F3_BLTU: op_sel = BLTU;
                    F3_BGEU: op_sel = BGEU;
                    default: op_sel = UNKNOWN;
                endcase
            end
            CLASS_LOAD: begin
                case (fields.funct3)
                    F3_LB:   op_sel = LB;
                    F3_LH:   op_sel = LH;
                    F3_LW:   op_sel = LW;
                    F3_LD:   op_sel = LD;
                    F3_LBU:  op_sel = LBU;
                    F3_LHU:  op_sel = LHU;
                    F3_LWU:  op_sel = LWU;
                    default: op_sel = UNKNOWN;
                endcase
            end
            CLASS_STORE: begin
                case (fields.funct3)
                    F3_SB:   op_sel = SB;
                    F3_SH:   op_sel = SH;
                    F3_SW:   op_sel = SW;
                    F3_SD:   op_sel = SD;
                    default: op_sel = UNKNOWN;
                endcase
            end
            CLASS_OP: begin
                // M extension funct7 values fall through to unknown
                case (fields.funct3)
                    F3_ADD_SUB: begin
                        if (fields.funct7 == F7_BASE) begin
                            op_sel = ADD;
                        end else if (fields.funct7 == F7_ALT) begin
                            op_sel = SUB;
                        end
                    end
                    F3_SRL_SRA: begin
                        if (fields.funct7 == F7_BASE) begin
                            op_sel = SRL;
                        end else if (fields.funct7 == F7_ALT) begin
                            op_sel = SRA;
                        end
                    end
                    F3_AND:  op_sel = (fields.funct7 == F7_BASE) ? AND : UNKNOWN;
                    F3_OR:   op_sel = (fields.funct7 == F7_BASE) ? OR : UNKNOWN;
                    F3_XOR:  op_sel = (fields.funct7 == F7_BASE) ? XOR : UNKNOWN;
                    F3_SLL:  op_sel = (fields.funct7 == F7_BASE) ? SLL : UNKNOWN;
                    F3_SLT:  op_sel = (fields.funct7 == F7_BASE) ? SLT : UNKNOWN;
                    F3_SLTU: op_sel = (fields.funct7 == F7_BASE) ? SLTU : UNKNOWN;
                    default: op_sel = UNKNOWN;
                endcase
            end
            CLASS_OP_IMM_32: begin
                case (fields.funct3)
                    F3_ADD_SUB: op_sel = ADDIW;
                    F3_SLL:     op_sel = (fields.funct6 == F6_BASE) ? SLLIW : UNKNOWN;
                    F3_SRL_SRA: begin
                        if (fields.funct6 == F6_BASE) begin
                            op_sel = SRLIW;
                        end else if (fields.funct6 == F6_ALT) begin
                            op_sel = SRAIW;
                        end
                    end
                    default:    op_sel = UNKNOWN;
                endcase
            end
            CLASS_OP_32: begin
                case (fields.funct3)
                    F3_ADD_SUB: begin
                        if (fields.funct7 == F7_BASE) begin
                            op_sel = ADDW;
                        end else if (fields.funct7 == F7_ALT) begin
                            op_sel = SUBW;
                        end
                    end
                    F3_SLL:     op_sel = (fields.funct7 == F7_BASE) ? SLLW : UNKNOWN;
                    F3_SRL_SRA: begin
                        if (fields.funct7 == F7_BASE) begin
                            op_sel = SRLW;
                        end else if (fields.funct7 == F7_ALT) begin
                            op_sel = SRAW;
                        end
                    end
                    default:    op_sel = UNKNOWN;
                endcase
            end
            default: op_sel = UNKNOWN;
        endcase
    end

    // then the remaining control bits depend on the operation alone
    always_comb begin
        ctl_d            = '0;
        ctl_d.op         = op_sel;
        ctl_d.regwrite   = 1'b1;
        case (op_sel)
            ADDI, ADD, ADDIW, ADDW, JAL, JALR, AUIPC: ctl_d.alufunc = ALU_ADD;
            SUB, SUBW:                     ctl_d.alufunc = ALU_SUB;
            ANDI, AND:                     ctl_d.alufunc = ALU_AND;
            ORI, OR:                       ctl_d.alufunc = ALU_OR;
            XORI, XOR:                     ctl_d.alufunc = ALU_XOR;
            SLTI, SLT:                     ctl_d.alufunc = ALU_SSMALL;
            SLTIU, SLTU:                   ctl_d.alufunc = ALU_USMALL;
            SLLI, SLL, SLLIW, SLLW:        ctl_d.alufunc = ALU_LEFT;
            SRLI, SRL:                     ctl_d.alufunc = ALU_URIGHT;
            SRAI, SRA:                     ctl_d.alufunc = ALU_SRIGHT;
            SRLIW, SRLW:                   ctl_d.alufunc = ALU_URIGHT_32;
            SRAIW, SRAW:                   ctl_d.alufunc = ALU_SRIGHT_32;
            LUI:                           ctl_d.alufunc = ALU_DIRECT;
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                ctl_d.alufunc  = ALU_PASS;
                ctl_d.regwrite = 1'b0;
            end
            LB, LH, LW, LD, LBU, LHU, LWU: begin
                ctl_d.alufunc    = ALU_PASS;
                ctl_d.mem_access = 1'b1;
            end
            SB, SH, SW, SD: begin
                ctl_d.alufunc    = ALU_DIRECT;
                ctl_d.regwrite   = 1'b0;
                ctl_d.mem_access = 1'b1;
            end
            default: ctl_d = '0;
        endcase
    end

    assign fields_ready = !valid_q || ctl_ready;
    assign accept       = fields_valid && fields_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (fields_ready) begin
            valid_q <= fields_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctl_q <= ctl_d;
        end
    end

    assign ctl_valid = valid_q;
    assign ctl       = ctl_q;

endmodule

`default_nettype wire

// ==== source/decode_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_pipeline (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  decode_pkg::instr_t   instr,
    output logic                 instr_ready,
    output logic                 ctl_valid,
    output decode_pkg::control_t ctl,
    input  logic                 ctl_ready
);
    import decode_pkg::*;

    // link between the classify and resolve stages
    logic           fields_valid;
    logic           fields_ready;
    decode_fields_t fields;

    opcode_classify u_classify (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_ready  (instr_ready),
        .fields_valid (fields_valid),
        .fields       (fields),
        .fields_ready (fields_ready)
    );

    subop_decode u_subop (
        .clk          (clk),
        .rst_n        (rst_n),
        .fields_valid (fields_valid),
        .fields       (fields),
        .fields_ready (fields_ready),
        .ctl_valid    (ctl_valid),
        .ctl          (ctl),
        .ctl_ready    (ctl_ready)
    );

endmodule

`default_nettype wire

// ==== verification/decode_pipeline_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_pipeline_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 ctl_valid,
    input decode_pkg::control_t ctl,
    input logic                 ctl_ready
);
    int fail_count = 0;

    // a stalled control word stays on the bus unchanged
    ctl_holds: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctl_valid && !ctl_ready) |=> (ctl_valid && $stable(ctl))
    ) else begin
        $error("ctl_valid or ctl changed while ctl_ready was low");
        fail_count++;
    end

    reset_clears_valid: assert property (
        @(posedge clk) !rst_n |=> !ctl_valid
    ) else begin
        $error("ctl_valid was high in the cycle after reset");
        fail_count++;
    end

endmodule

bind decode_pipeline decode_pipeline_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctl_valid (ctl_valid),
    .ctl       (ctl),
    .ctl_ready (ctl_ready)
);

`default_nettype wire

// ==== verification/decode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 instr_valid,
    input  decode_pkg::instr_t   instr,
    input  logic                 instr_ready,
    input  logic                 ctl_valid,
    input  decode_pkg::control_t ctl,
    input  logic                 ctl_ready,
    input  logic                 end_of_test,
    output int                   error_count,
    output int                   pending
);
    import decode_pkg::*;

    // operations indexed by funct3
    localparam op_t IMM_OPS [8]  = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
    localparam op_t REG_OPS [8]  = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    localparam op_t REG_ALT [8]  = '{SUB, UNKNOWN, UNKNOWN, UNKNOWN, UNKNOWN, SRA,
                                     UNKNOWN, UNKNOWN};
    localparam op_t W_OPS [8]    = '{ADDW, SLLW, UNKNOWN, UNKNOWN, UNKNOWN, SRLW,
                                     UNKNOWN, UNKNOWN};
    localparam op_t W_ALT [8]    = '{SUBW, UNKNOWN, UNKNOWN, UNKNOWN, UNKNOWN, SRAW,
                                     UNKNOWN, UNKNOWN};
    localparam op_t IMMW_OPS [8] = '{ADDIW, SLLIW, UNKNOWN, UNKNOWN, UNKNOWN, SRLIW,
                                     UNKNOWN, UNKNOWN};
    localparam op_t IMMW_ALT [8] = '{ADDIW, UNKNOWN, UNKNOWN, UNKNOWN, UNKNOWN, SRAIW,
                                     UNKNOWN, UNKNOWN};
    localparam op_t BR_OPS [8]   = '{BEQ, BNE, UNKNOWN, UNKNOWN, BLT, BGE, BLTU, BGEU};
    localparam op_t LOAD_OPS [8] = '{LB, LH, LW, LD, LBU, LHU, LWU, UNKNOWN};
    localparam op_t ST_OPS [8]   = '{SB, SH, SW, SD, UNKNOWN, UNKNOWN, UNKNOWN, UNKNOWN};

    instr_t instr_q[$];
    int     accept_cycle_q[$];
    int     cycle = 0;
    int     last_stall = 0;
    int     errors = 0;
    logic   end_seen = 1'b0;

    function automatic op_t pick_alt(input logic base, input logic alt,
                                     input op_t base_op, input op_t alt_op);
        if (base) begin
            return base_op;
        end
        return alt ? alt_op : UNKNOWN;
    endfunction

    function automatic op_t expected_op(input instr_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [5:0] f6;
        f3 = w[14:12];
        f7 = w[31:25];
        f6 = w[31:26];
        case (w[6:0])
            7'b0010011: begin
                if (f3 == 3'd5) begin
                    return pick_alt(f6 == 6'h00, f6 == 6'h10, SRLI, SRAI);
                end
                return IMM_OPS[f3];
            end
            7'b0110111: return LUI;
            7'b0010111: return AUIPC;
            7'b1101111: return JAL;
            7'b1100111: return (f3 == 3'd0) ? JALR : UNKNOWN;
            7'b1100011: return BR_OPS[f3];
            7'b0000011: return LOAD_OPS[f3];
            7'b0100011: return ST_OPS[f3];
            7'b0110011: return pick_alt(f7 == 7'h00, f7 == 7'h20, REG_OPS[f3], REG_ALT[f3]);
            7'b0111011: return pick_alt(f7 == 7'h00, f7 == 7'h20, W_OPS[f3], W_ALT[f3]);
            7'b0011011: begin
                if (f3 == 3'd0) begin
                    return ADDIW;
                end
                return pick_alt(f6 == 6'h00, f6 == 6'h10, IMMW_OPS[f3], IMMW_ALT[f3]);
            end
            default: return UNKNOWN;
        endcase
    endfunction

    function automatic alu_func_t alu_for(input op_t op);
        case (op)
            ADD, ADDI, ADDW, ADDIW, AUIPC, JAL, JALR: return ALU_ADD;
            SUB, SUBW:                               return ALU_SUB;
            AND, ANDI:                               return ALU_AND;
            OR, ORI:                                 return ALU_OR;
            XOR, XORI:                               return ALU_XOR;
            SLT, SLTI:                               return ALU_SSMALL;
            SLTU, SLTIU:                             return ALU_USMALL;
            SLL, SLLI, SLLW, SLLIW:                  return ALU_LEFT;
            SRL, SRLI:                               return ALU_URIGHT;
            SRA, SRAI:                               return ALU_SRIGHT;
            SRLW, SRLIW:                             return ALU_URIGHT_32;
            SRAW, SRAIW:                             return ALU_SRIGHT_32;
            LUI, SB, SH, SW, SD:                     return ALU_DIRECT;
            default:                                 return ALU_PASS;
        endcase
    endfunction

    function automatic control_t expected_control(input instr_t w);
        control_t c;
        op_t      op;
        op = expected_op(w);
        c  = '0;
        if (op != UNKNOWN) begin
            c.op         = op;
            c.alufunc    = alu_for(op);
            c.mem_access = op inside {LB, LH, LW, LD, LBU, LHU, LWU, SB, SH, SW, SD};
            c.regwrite   = !(op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, SB, SH, SW, SD});
        end
        return c;
    endfunction

    function automatic string describe(input control_t c);
        return $sformatf("op %0d alu %0d rw %b mem %b", c.op, c.alufunc, c.regwrite,
                         c.mem_access);
    endfunction

    always @(posedge clk) begin
        instr_t   word;
        int       accepted_at;
        control_t exp;
        cycle++;
        if (rst_n) begin
            if (!ctl_ready) begin
                last_stall = cycle;
            end
            if (ctl_valid && ctl_ready) begin
                if (instr_q.size() == 0) begin
                    $display("At %0t ns a control word came out with no instruction pending",
                             $time);
                    errors++;
                end else begin
                    word        = instr_q.pop_front();
                    accepted_at = accept_cycle_q.pop_front();
                    exp         = expected_control(word);
                    if (ctl !== exp) begin
                        $display("[ERROR] %0t ns: instr %h expected %s, got %s",
                                 $time, word, describe(exp), describe(ctl));
                        errors++;
                    end
                    // without a stall since the accept the latency is exactly two
                    if (last_stall <= accepted_at && cycle - accepted_at != 2) begin
                        $display("[ERROR] %0t ns: instr %h took %0d cycles, expected 2",
                                 $time, word, cycle - accepted_at);
                        errors++;
                    end
                end
            end
            if (instr_valid && instr_ready) begin
                instr_q.push_back(instr);
                accept_cycle_q.push_back(cycle);
            end
        end
        if (end_of_test && !end_seen) begin
            end_seen = 1'b1;
            if (instr_q.size() != 0) begin
                $display("%0d accepted instructions never came out of the pipeline",
                         instr_q.size());
                errors++;
            end
        end
        pending     = instr_q.size();
        error_count = errors;
    end

endmodule

`default_nettype wire

// ==== verification/decode_pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_pipeline_tb;
    import decode_pkg::*;

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_INSTR    = 3000;
    localparam int          BURST_LEN    = 200;
    localparam int          TIMEOUT_NS   = NUM_INSTR * 4 * CLK_PERIOD
                                         + RESET_CYCLES * CLK_PERIOD + 400;
    localparam logic [15:0] LFSR_SEED    = 16'd40;
    localparam logic [6:0]  OPCODES [11] = '{
        OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
        OPC_LOAD, OPC_STORE, OPC_OP, OPC_OP_IMM_32, OPC_OP_32
    };

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    instr_t      instr;
    logic        instr_ready;
    logic        ctl_valid;
    control_t    ctl;
    logic        ctl_ready;
    logic        end_of_test;
    int          checker_errors;
    int          pending;
    int          reset_errors = 0;
    logic [15:0] lfsr_state = LFSR_SEED;

    always #(CLK_PERIOD / 2) clk = ~clk;

    decode_pipeline UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .ctl_valid   (ctl_valid),
        .ctl         (ctl),
        .ctl_ready   (ctl_ready)
    );

    decode_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .ctl_valid   (ctl_valid),
        .ctl         (ctl),
        .ctl_ready   (ctl_ready),
        .end_of_test (end_of_test),
        .error_count (checker_errors),
        .pending     (pending)
    );

    // taps 16, 14, 13 and 11 give a maximal length sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    // three in four words follow a legal opcode, the rest are fully random
    task automatic make_instr(output instr_t w);
        logic [31:0] kind;
        logic [31:0] bits;
        logic [6:0]  f7;
        random_bits(2, kind);
        if (kind == 0) begin
            random_bits(32, bits);
            w = bits;
        end else begin
            random_bits(4, kind);
            random_bits(3, bits);
            // the rarer choices are shamt[5] for shifts, the M extension funct7
            // and any funct7 at all
            case (bits[2:0])
                3'd0, 3'd1: f7 = F7_BASE;
                3'd2, 3'd3: f7 = F7_ALT;
                3'd4:       f7 = {F6_ALT, 1'b1};
                3'd5:       f7 = 7'b0000001;
                default: begin
                    random_bits(7, bits);
                    f7 = bits[6:0];
                end
            endcase
            random_bits(18, bits);
            w = {f7, bits[17:8], bits[7:5], bits[4:0], OPCODES[4'(kind % 11)]};
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the pipeline did not drain", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        instr_t      word;
        logic [31:0] r;
        int          sent;
        int          total;
        logic        holding;
        $timeformat(-9, 0, "", 0);
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        ctl_ready   = 1'b0;
        end_of_test = 1'b0;
        sent        = 0;
        holding     = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;
        ctl_ready = 1'b1;
        if (!instr_ready || ctl_valid) begin
            $display("[ERROR] %0t ns: after reset instr_ready %b ctl_valid %b",
                     $time, instr_ready, ctl_valid);
            reset_errors++;
        end
        // the first burst runs at full rate, then valid and ready go random
        while (sent < NUM_INSTR) begin
            if (!holding) begin
                r = 1;
                if (sent >= BURST_LEN) begin
                    random_bits(2, r);
                end
                if (r != 0) begin
                    make_instr(word);
                    instr   = word;
                    holding = 1'b1;
                end
                instr_valid = holding;
            end
            if (sent >= BURST_LEN) begin
                random_bits(1, r);
                ctl_ready = r[0];
            end
            @(posedge clk);
            if (instr_valid && instr_ready) begin
                sent++;
                holding = 1'b0;
            end
            @(negedge clk);
        end
        instr_valid = 1'b0;
        ctl_ready   = 1'b1;
        wait (pending == 0);
        @(negedge clk);
        end_of_test = 1'b1;
        @(negedge clk);
        total = checker_errors + reset_errors + UUT.u_asserts.fail_count;
        $display("Errors: %0d from the checker, %0d at reset, %0d from assertions",
                 checker_errors, reset_errors, UUT.u_asserts.fail_count);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/decode_pkg.sv
source/opcode_classify.sv
source/subop_decode.sv
source/decode_pipeline.sv
verification/decode_pipeline_asserts.sv
verification/decode_checker.sv
verification/decode_pipeline_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= decode_pipeline_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv verification/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
